// File: verilog/stack_cpu_pkg.sv
// ------------------------------
// Stack CPU shared definitions
// Word, address and instruction types, opcodes
// and the sequencer state encoding
// ------------------------------

package stack_cpu_pkg;

	typedef logic [15:0] word_t;     // Acc, stack and port data
	typedef logic [7:0]  iaddr_t;    // Instruction address
	typedef logic [11:0] instr_t;    // Opcode in [11:8], operand in [7:0]
	typedef logic [3:0]  opcode_t;
	typedef logic [7:0]  operand_t;  // Immediate or jump target

	// Opcodes ----------------------
	localparam opcode_t OP_NOP = 4'd0;
	localparam opcode_t OP_LOD = 4'd1;   // Acc = operand
	localparam opcode_t OP_PSH = 4'd2;   // Push acc
	localparam opcode_t OP_POP = 4'd3;   // Acc = pop
	localparam opcode_t OP_ADD = 4'd4;   // Acc = pop + acc
	localparam opcode_t OP_SUB = 4'd5;   // Acc = pop - acc
	localparam opcode_t OP_AND = 4'd6;
	localparam opcode_t OP_XOR = 4'd7;
	localparam opcode_t OP_SHL = 4'd8;   // Shift by operand[3:0]
	localparam opcode_t OP_OUT = 4'd9;   // Send acc
	localparam opcode_t OP_INN = 4'd10;  // Acc = io_in
	localparam opcode_t OP_HLT = 4'd11;
	localparam opcode_t OP_JMP = 4'd12;
	localparam opcode_t OP_JIZ = 4'd13;  // Jump when acc is zero
	localparam opcode_t OP_CAL = 4'd14;
	localparam opcode_t OP_RET = 4'd15;

	// Sequencer states -------------
	typedef enum logic [1:0] {
		S_RUN,    // Normal execution
		S_STALL,  // OUT waiting for a credit
		S_HALT,   // Stopped by HLT
		S_FAULT   // Stack overflow or underflow
	} seq_state_e;

endpackage

// File: verilog/prog_counter.sv
// ------------------------------
// Program counter
// Holds, jumps, returns or steps the fetch address
// ------------------------------

`timescale 1ns/1ns

module prog_counter import stack_cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     pc_hold,   // Stall, halt or fault
	input  logic     pc_jump,   // JMP, taken JIZ, CAL
	input  logic     pc_ret,    // RET
	input  operand_t target,
	input  iaddr_t   ret_addr,
	output iaddr_t   pc
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (pc_ret) begin
			pc <= ret_addr;                // Back to the caller
		end else if (pc_jump) begin
			pc <= iaddr_t'(target);
		end else if (!pc_hold) begin
			pc <= pc + iaddr_t'(1);        // Wraps at the top of the ROM
		end
	end

endmodule

// File: verilog/seq_ctrl.sv
// ------------------------------
// Sequencer
// Decodes the opcode, checks stack limits and output
// credits, drives every enable and picks the next state
// ------------------------------

`timescale 1ns/1ns

module seq_ctrl import stack_cpu_pkg::*; #(
	parameter int OUT_CREDITS = 2
) (
	input  logic    clk,
	input  logic    rst,
	input  opcode_t opcode,
	input  logic    acc_zero,
	input  logic    ds_full,
	input  logic    ds_empty,
	input  logic    cs_full,
	input  logic    cs_empty,
	input  logic    out_credit,   // One credit back per high cycle
	output logic    pc_hold,
	output logic    pc_jump,
	output logic    pc_ret,
	output logic    ds_push,
	output logic    ds_pop,
	output logic    cs_push,
	output logic    cs_pop,
	output logic    acc_en,
	output logic    out_valid,
	output logic    halted,
	output logic    fault
);

	localparam int CW = $clog2(OUT_CREDITS + 1);

	seq_state_e    state, state_next;
	logic [CW-1:0] credit_cnt;    // Credits the receiver still grants

	logic ds_user, ds_prod, is_branch, is_call, is_ret, is_out, is_halt, is_alu;
	logic active, stack_err, out_blocked, exec;

	// Opcode classes ---------------
	assign ds_user   = (opcode == OP_POP) || (opcode == OP_ADD) || (opcode == OP_SUB)
	                || (opcode == OP_AND) || (opcode == OP_XOR);
	assign ds_prod   = (opcode == OP_PSH);
	assign is_branch = (opcode == OP_JMP) || ((opcode == OP_JIZ) && acc_zero); // Taken only
	assign is_call   = (opcode == OP_CAL);
	assign is_ret    = (opcode == OP_RET);
	assign is_out    = (opcode == OP_OUT);
	assign is_halt   = (opcode == OP_HLT);
	assign is_alu    = ds_user || (opcode == OP_LOD) || (opcode == OP_SHL)
	                || (opcode == OP_INN);

	// Stall re-runs the same OUT, so it decodes like run
	assign active      = (state == S_RUN) || (state == S_STALL);
	assign stack_err   = (ds_user && ds_empty) || (ds_prod && ds_full)
	                  || (is_call && cs_full) || (is_ret && cs_empty);
	assign out_blocked = is_out && (credit_cnt == '0);   // Count before any return
	assign exec        = active && !stack_err && !out_blocked && !is_halt;

	// Enables ----------------------
	assign pc_hold   = !exec;
	assign pc_jump   = exec && (is_branch || is_call);
	assign pc_ret    = exec && is_ret;
	assign ds_push   = exec && ds_prod;
	assign ds_pop    = exec && ds_user;
	assign cs_push   = exec && is_call;
	assign cs_pop    = exec && is_ret;
	assign acc_en    = exec && is_alu;
	assign out_valid = exec && is_out;
	assign halted    = (state == S_HALT);
	assign fault     = (state == S_FAULT);

	always_comb begin
		state_next = state;           // Halt and fault stay until reset
		if (active) begin
			if (stack_err)
				state_next = S_FAULT;
			else if (is_halt)
				state_next = S_HALT;
			else if (out_blocked)
				state_next = S_STALL;
			else
				state_next = S_RUN;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= S_RUN;
		else
			state <= state_next;
	end

	// Credit counter ---------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credit_cnt <= CW'(OUT_CREDITS);
		end else begin
			case ({out_credit, out_valid})
				2'b10: if (credit_cnt != CW'(OUT_CREDITS))
					credit_cnt <= credit_cnt + CW'(1);  // Saturates at the limit
				2'b01: credit_cnt <= credit_cnt - CW'(1);
				default: ;                               // Return and send cancel
			endcase
		end
	end

endmodule

// File: verilog/call_stack.sv
// ------------------------------
// Call stack
// Return addresses for CAL and RET with fill flags
// ------------------------------

`timescale 1ns/1ns

module call_stack import stack_cpu_pkg::*; #(
	parameter int CALL_DEPTH = 4
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   cs_push,
	input  logic   cs_pop,
	input  iaddr_t pc,          // Address of the CAL itself
	output iaddr_t ret_addr,
	output logic   cs_full,
	output logic   cs_empty
);

	localparam int AW = (CALL_DEPTH > 1) ? $clog2(CALL_DEPTH) : 1;
	localparam int CW = $clog2(CALL_DEPTH + 1);

	iaddr_t        mem [CALL_DEPTH];
	logic [CW-1:0] cs_cnt;      // Entries in use
	logic [AW-1:0] top_idx;

	assign top_idx  = AW'(cs_cnt - CW'(1));
	assign ret_addr = mem[top_idx];                  // Valid only when not empty
	assign cs_full  = (cs_cnt == CW'(CALL_DEPTH));
	assign cs_empty = (cs_cnt == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cs_cnt <= '0;
		else if (cs_push)
			cs_cnt <= cs_cnt + CW'(1);
		else if (cs_pop)
			cs_cnt <= cs_cnt - CW'(1);
	end

	// Entry storage
	always_ff @(posedge clk) begin
		if (cs_push)
			mem[cs_cnt[AW-1:0]] <= pc + iaddr_t'(1);  // Resume after the CAL
	end

endmodule

// File: verilog/data_stack.sv
// ------------------------------
// Data stack
// Operand storage with a pointer counting down
// from the top and a combinational top read
// ------------------------------

`timescale 1ns/1ns

module data_stack import stack_cpu_pkg::*; #(
	parameter int DATA_DEPTH = 8
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  ds_push,
	input  logic  ds_pop,
	input  word_t push_data,
	output word_t ds_top,
	output logic  ds_full,
	output logic  ds_empty
);

	localparam int AW = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
	localparam int CW = $clog2(DATA_DEPTH + 1);

	word_t         mem [DATA_DEPTH];
	logic [CW-1:0] sp;           // Points at the top entry
	logic [AW-1:0] wr_idx;       // Slot below the top

	// ------------------------------
	// Pointer
	// ------------------------------
	// Empty at DATA_DEPTH, full at zero
	assign ds_empty = (sp == CW'(DATA_DEPTH));
	assign ds_full  = (sp == '0);
	assign wr_idx   = AW'(sp - CW'(1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sp <= CW'(DATA_DEPTH);
		else if (ds_push)
			sp <= sp - CW'(1);     // Grows downward
		else if (ds_pop)
			sp <= sp + CW'(1);
	end

	// ------------------------------
	// Storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (ds_push)
			mem[wr_idx] <= push_data;
	end

	// Same cycle read, so pop and ALU op retire together
	assign ds_top = mem[sp[AW-1:0]];

endmodule

// File: verilog/alu_acc.sv
// ------------------------------
// Accumulator and ALU
// Next accumulator value selected by opcode
// ------------------------------

`timescale 1ns/1ns

module alu_acc import stack_cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     acc_en,     // Set only for executed ALU opcodes
	input  opcode_t  opcode,
	input  operand_t operand,
	input  word_t    ds_top,     // Value being popped
	input  word_t    io_in,
	output word_t    acc,
	output logic     acc_zero
);

	word_t acc_next;

	// ------------------------------
	// Function select
	// ------------------------------
	always_comb begin
		case (opcode)
			OP_LOD:  acc_next = word_t'(operand);       // Zero extended
			OP_POP:  acc_next = ds_top;
			OP_ADD:  acc_next = ds_top + acc;
			OP_SUB:  acc_next = ds_top - acc;           // Stack minus acc
			OP_AND:  acc_next = ds_top & acc;
			OP_XOR:  acc_next = ds_top ^ acc;
			OP_SHL:  acc_next = acc << operand[3:0];    // Upper bits drop off
			OP_INN:  acc_next = io_in;
			default: acc_next = acc;
		endcase
	end

	// ------------------------------
	// Register
	// ------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else if (acc_en)
			acc <= acc_next;
	end

	// JIZ condition
	assign acc_zero = (acc == '0);

endmodule

// File: verilog/stack_cpu.sv
// ------------------------------
// Stack CPU core
// Accumulator machine with data and call stacks,
// one input port and a credit based output port
// ------------------------------

`timescale 1ns/1ns

module stack_cpu import stack_cpu_pkg::*; #(
	parameter int DATA_DEPTH  = 8,
	parameter int CALL_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic   clk,
	input  logic   rst,
	input  instr_t instr,        // From the ROM, same cycle
	input  word_t  io_in,
	input  logic   out_credit,
	output iaddr_t instr_addr,
	output word_t  out_data,
	output logic   out_valid,
	output logic   halted,
	output logic   fault
);

	opcode_t  opcode;
	operand_t operand;
	iaddr_t   pc, ret_addr;
	word_t    acc, ds_top;
	logic     pc_hold, pc_jump, pc_ret;
	logic     ds_push, ds_pop, ds_full, ds_empty;
	logic     cs_push, cs_pop, cs_full, cs_empty;
	logic     acc_en, acc_zero;

	// Instruction fields
	assign opcode     = instr[11:8];
	assign operand    = instr[7:0];
	assign instr_addr = pc;
	assign out_data   = acc;     // Valid with out_valid

	// ------------------------------
	// Fetch
	// ------------------------------
	prog_counter u_pc (
		.clk      (clk),
		.rst      (rst),
		.pc_hold  (pc_hold),
		.pc_jump  (pc_jump),
		.pc_ret   (pc_ret),
		.target   (operand),
		.ret_addr (ret_addr),
		.pc       (pc)
	);

	seq_ctrl #(.OUT_CREDITS(OUT_CREDITS)) u_seq (
		.clk        (clk),
		.rst        (rst),
		.opcode     (opcode),
		.acc_zero   (acc_zero),
		.ds_full    (ds_full),
		.ds_empty   (ds_empty),
		.cs_full    (cs_full),
		.cs_empty   (cs_empty),
		.out_credit (out_credit),
		.pc_hold    (pc_hold),
		.pc_jump    (pc_jump),
		.pc_ret     (pc_ret),
		.ds_push    (ds_push),
		.ds_pop     (ds_pop),
		.cs_push    (cs_push),
		.cs_pop     (cs_pop),
		.acc_en     (acc_en),
		.out_valid  (out_valid),
		.halted     (halted),
		.fault      (fault)
	);

	call_stack #(.CALL_DEPTH(CALL_DEPTH)) u_cs (
		.clk      (clk),
		.rst      (rst),
		.cs_push  (cs_push),
		.cs_pop   (cs_pop),
		.pc       (pc),
		.ret_addr (ret_addr),
		.cs_full  (cs_full),
		.cs_empty (cs_empty)
	);

	// ------------------------------
	// Datapath
	// ------------------------------
	data_stack #(.DATA_DEPTH(DATA_DEPTH)) u_ds (
		.clk       (clk),
		.rst       (rst),
		.ds_push   (ds_push),
		.ds_pop    (ds_pop),
		.push_data (acc),        // PSH always stores acc
		.ds_top    (ds_top),
		.ds_full   (ds_full),
		.ds_empty  (ds_empty)
	);

	alu_acc u_alu (
		.clk      (clk),
		.rst      (rst),
		.acc_en   (acc_en),
		.opcode   (opcode),
		.operand  (operand),
		.ds_top   (ds_top),
		.io_in    (io_in),
		.acc      (acc),
		.acc_zero (acc_zero)
	);

endmodule

// File: testbench/tb_clock.sv
// ------------------------------
// Testbench clock
// Free running clock, 20 ns period
// ------------------------------

`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;   // Half period per phase

endmodule

// File: testbench/stack_cpu_sva.sv
// ------------------------------
// Sequencer assertions
// Credit limits, exclusive stop states, pc hold
// ------------------------------

`timescale 1ns/1ns

module stack_cpu_sva import stack_cpu_pkg::*; #(
	parameter int OUT_CREDITS = 2
) (
	input logic                               clk,
	input logic                               rst,
	input logic                               out_valid,
	input logic                               halted,
	input logic                               fault,
	input logic                               pc_hold,
	input seq_state_e                         state,
	input logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt
);

	// Credit bookkeeping ------------
	a_send_needs_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (credit_cnt != '0))
		else $error("out_valid raised with no credit left");

	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		int'(credit_cnt) <= OUT_CREDITS)
		else $error("credit count above its limit");

	// Stop states -------------------
	a_stop_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(halted && fault))
		else $error("halted and fault high together");

	a_stop_holds_pc: assert property (@(posedge clk) disable iff (rst)
		((state == S_HALT) || (state == S_FAULT)) |-> pc_hold)
		else $error("pc not held while stopped");

endmodule

bind seq_ctrl stack_cpu_sva #(.OUT_CREDITS(OUT_CREDITS)) u_sva (
	.clk        (clk),
	.rst        (rst),
	.out_valid  (out_valid),
	.halted     (halted),
	.fault      (fault),
	.pc_hold    (pc_hold),
	.state      (state),
	.credit_cnt (credit_cnt)
);

// File: testbench/stack_cpu_tb.sv
// ------------------------------
// Stack CPU testbench
// Instruction ROM model, directed program tests
// and output collection
// ------------------------------

`timescale 1ns/1ns

module stack_cpu_tb import stack_cpu_pkg::*; ();

	localparam int DATA_DEPTH  = 8;    // Core defaults
	localparam int OUT_CREDITS = 2;

	logic   clk, rst, out_credit, out_valid, halted, fault;
	instr_t instr;
	iaddr_t instr_addr;
	word_t  io_in, out_data;

	instr_t rom [256];
	iaddr_t fill_ptr;                   // Next ROM slot for emit
	word_t  outq[$];                    // Words seen on the output port
	word_t  expq[$];
	integer seed;

	tb_clock u_clk (.clk(clk));

	stack_cpu #(
		.DATA_DEPTH  (DATA_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.io_in      (io_in),
		.out_credit (out_credit),
		.instr_addr (instr_addr),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.halted     (halted),
		.fault      (fault)
	);

	assign instr = rom[instr_addr];    // Combinational ROM

	// Output collector samples mid cycle
	always @(negedge clk) begin
		if (!rst && out_valid)
			outq.push_back(out_data);
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_addr(input string name, input iaddr_t exp, input iaddr_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic clear_rom();
		int a;
		for (a = 0; a < 256; a++)
			rom[iaddr_t'(a)] = {OP_HLT, operand_t'(a)};   // Stray fetch halts
		fill_ptr = '0;
	endtask

	task automatic emit(input opcode_t op, input operand_t arg);
		rom[fill_ptr] = {op, arg};
		fill_ptr = fill_ptr + iaddr_t'(1);
	endtask

	// Reset for 3 cycles and check the stop flags and fetch address
	task automatic restart(input string name);
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		outq.delete();
		expq.delete();
		@(negedge clk);
		check_flag({name, " fault after reset"}, 1'b0, fault);
		check_flag({name, " halted after reset"}, 1'b0, halted);
		check_addr({name, " instr_addr after reset"}, 8'd0, instr_addr);
	endtask

	task automatic wait_stop(input string name, input int limit);
		int t;
		t = 0;
		while (!(halted || fault)) begin
			@(negedge clk);
			t++;
			if (t > limit)
				abort_run({name, ": core never halted or faulted"});
		end
	endtask

	task automatic wait_outputs(input string name, input int n, input int limit);
		int t;
		t = 0;
		while (outq.size() < n) begin
			@(negedge clk);
			t++;
			if (t > limit)
				abort_run({name, ": expected output word never arrived"});
		end
	endtask

	task automatic expect_outputs(input string name);
		int i;
		check_word({name, " output count"}, word_t'(expq.size()), word_t'(outq.size()));
		for (i = 0; i < expq.size(); i++)
			check_word($sformatf("%s output %0d", name, i), expq[i], outq[i]);
	endtask

	// Stop flags and the held fetch address
	task automatic check_stop(input string name, input logic exp_halt, input logic exp_fault,
			input iaddr_t exp_addr);
		check_flag({name, " halted"}, exp_halt, halted);
		check_flag({name, " fault"}, exp_fault, fault);
		check_addr({name, " instr_addr"}, exp_addr, instr_addr);
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_arithmetic();
		clear_rom();
		emit(OP_LOD, 8'd7);
		emit(OP_PSH, 8'd0);
		emit(OP_LOD, 8'd5);
		emit(OP_ADD, 8'd0);    // 7 + 5
		emit(OP_OUT, 8'd0);
		emit(OP_PSH, 8'd0);
		emit(OP_LOD, 8'd3);
		emit(OP_SUB, 8'd0);    // Stack minus acc
		emit(OP_OUT, 8'd0);
		emit(OP_HLT, 8'd0);    // 9
		@(posedge clk);
		out_credit <= 1'b1;    // Credit back every cycle
		restart("arith");
		wait_stop("arith", 100);
		expq.push_back(16'd12);
		expq.push_back(16'd9);
		expect_outputs("arith");
		check_stop("arith", 1'b1, 1'b0, 8'd9);
	endtask

	task automatic test_control_flow();
		clear_rom();
		emit(OP_LOD, 8'd0);    // 0
		emit(OP_JIZ, 8'd4);    // 1 taken
		emit(OP_LOD, 8'hee);   // 2
		emit(OP_OUT, 8'd0);    // 3 skipped
		emit(OP_LOD, 8'd1);    // 4
		emit(OP_JIZ, 8'd9);    // 5 not taken
		emit(OP_LOD, 8'h11);   // 6
		emit(OP_OUT, 8'd0);    // 7
		emit(OP_CAL, 8'd20);   // 8
		emit(OP_LOD, 8'h22);   // 9 return point
		emit(OP_OUT, 8'd0);    // 10
		emit(OP_JMP, 8'd14);   // 11
		emit(OP_LOD, 8'h33);   // 12
		emit(OP_OUT, 8'd0);    // 13 skipped
		emit(OP_HLT, 8'd0);    // 14
		// Subroutine
		fill_ptr = 8'd20;
		emit(OP_LOD, 8'h55);
		emit(OP_OUT, 8'd0);
		emit(OP_RET, 8'd0);
		@(posedge clk);
		out_credit <= 1'b1;
		restart("control");
		wait_stop("control", 100);
		expq.push_back(16'h0011);
		expq.push_back(16'h0055);   // Marker from the call
		expq.push_back(16'h0022);
		expect_outputs("control");
		check_stop("control", 1'b1, 1'b0, 8'd14);
	endtask

	task automatic test_credit_backpressure();
		int i;
		clear_rom();
		for (i = 0; i < 6; i++) begin
			emit(OP_LOD, operand_t'(8'h40 + i));
			emit(OP_OUT, 8'd0);
		end
		emit(OP_HLT, 8'd0);    // 12
		@(posedge clk);
		out_credit <= 1'b0;    // Receiver holds every credit
		restart("credit");
		wait_outputs("credit", OUT_CREDITS, 50);
		// Nothing more may leave while stalled
		for (i = 0; i < 40; i++)
			@(negedge clk);
		check_word("credit stalled count", word_t'(OUT_CREDITS), word_t'(outq.size()));
		check_stop("credit stalled", 1'b0, 1'b0, iaddr_t'(2 * OUT_CREDITS + 1));
		// One credit at a time
		for (i = OUT_CREDITS; i < 6; i++) begin
			@(posedge clk);
			out_credit <= 1'b1;
			@(posedge clk);
			out_credit <= 1'b0;
			wait_outputs("credit", i + 1, 20);
		end
		wait_stop("credit", 50);
		for (i = 0; i < 6; i++)
			expq.push_back(word_t'(16'h40 + i));
		expect_outputs("credit");
		check_stop("credit", 1'b1, 1'b0, 8'd12);
	endtask

	task automatic test_logic_input();
		int     n;
		word_t  v;
		operand_t k, s;
		for (n = 0; n < 4; n++) begin
			v = word_t'($random(seed));
			k = operand_t'($random(seed));
			s = operand_t'($random(seed)) & 8'h0f;   // Shift range 0 to 15
			clear_rom();
			emit(OP_INN, 8'd0);
			emit(OP_PSH, 8'd0);
			emit(OP_LOD, k);
			emit(OP_XOR, 8'd0);
			emit(OP_OUT, 8'd0);
			emit(OP_INN, 8'd0);
			emit(OP_SHL, s);
			emit(OP_OUT, 8'd0);
			emit(OP_HLT, 8'd0);    // 8
			@(posedge clk);
			io_in      <= v;
			out_credit <= 1'b1;
			restart("logic");
			wait_stop("logic", 100);
			expq.push_back(v ^ word_t'(k));
			expq.push_back(v << s[3:0]);      // Upper bits drop off
			expect_outputs($sformatf("logic run %0d", n));
			check_stop("logic", 1'b1, 1'b0, 8'd8);
		end
	endtask

	// Fault must stop the core with no output word
	task automatic expect_fault(input string name, input iaddr_t stop_addr);
		wait_stop(name, 100);
		check_stop(name, 1'b0, 1'b1, stop_addr);
		expect_outputs(name);
	endtask

	task automatic test_stack_faults();
		int i;
		// Underflow on the data stack
		clear_rom();
		emit(OP_POP, 8'd0);
		emit(OP_OUT, 8'd0);
		emit(OP_HLT, 8'd0);
		@(posedge clk);
		out_credit <= 1'b1;
		restart("pop empty");
		expect_fault("pop empty", 8'd0);
		// Overflow where the trailing OUT must never run
		clear_rom();
		emit(OP_LOD, 8'h5a);
		for (i = 0; i <= DATA_DEPTH; i++)
			emit(OP_PSH, 8'd0);
		emit(OP_OUT, 8'd0);
		emit(OP_HLT, 8'd0);
		restart("push full");
		expect_fault("push full", iaddr_t'(DATA_DEPTH + 1));
		// Return with no call
		clear_rom();
		emit(OP_RET, 8'd0);
		emit(OP_HLT, 8'd0);
		restart("ret empty");
		expect_fault("ret empty", 8'd0);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		seed       = 32'hcaab;
		rst        = 1'b1;
		io_in      = '0;
		out_credit = 1'b0;
		clear_rom();
		test_arithmetic();
		test_control_flow();
		test_credit_backpressure();
		test_logic_input();
		test_stack_faults();
		restart("final");      // Last fault must clear
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: project.f
verilog/stack_cpu_pkg.sv
verilog/prog_counter.sv
verilog/seq_ctrl.sv
verilog/call_stack.sv
verilog/data_stack.sv
verilog/alu_acc.sv
verilog/stack_cpu.sv
testbench/tb_clock.sv
testbench/stack_cpu_sva.sv
testbench/stack_cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the stack CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module stack_cpu_tb -o sim_stack_cpu
./obj_dir/sim_stack_cpu | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi
